//--- Bender.yml
package:
  name: cpu_front

sources:
  - logic/cpu_front_pkg.sv
  - logic/halfword_if.sv
  - logic/halfword_splitter.sv
  - logic/instr_queue.sv
  - logic/thumb_expander.sv
  - logic/decode_stage.sv
  - logic/cpu_front_top.sv
  - target: simulation
    files:
      - sim/cpu_front_tb.sv

//--- logic/cpu_front_pkg.sv
package cpu_front_pkg;

// --------------------------------------------------
// Geometry
// --------------------------------------------------

// Entries in the halfword queue
localparam int QUEUE_DEPTH = 4;

// Read and write pointer width, wraps naturally at QUEUE_DEPTH
localparam int PTR_W = 2;

// Occupancy count must reach QUEUE_DEPTH itself
localparam int COUNT_W = 3;

// One compressed instruction
localparam int HALF_W = 16;

// Program counter width
localparam int ADDR_W = 32;

// --------------------------------------------------
// Encodings
// --------------------------------------------------

// Compressed opcode, bits 15 to 13 of the halfword
typedef enum logic [2:0] {
        C_MOVI = 3'd0,
        C_ADDR = 3'd1,
        C_SUBR = 3'd2,
        C_ADDI = 3'd3,
        C_LDR  = 3'd4,
        C_STR  = 3'd5,
        C_B    = 3'd6,
        C_UND  = 3'd7
} c_op_e;

// Opcode of the internal 32-bit form
typedef enum logic [3:0] {
        E_MOV = 4'd0,
        E_ADD = 4'd1,
        E_SUB = 4'd2,
        E_LDR = 4'd3,
        E_STR = 4'd4,
        E_B   = 4'd5,
        E_UND = 4'd6,
        E_IRQ = 4'd7
} exp_op_e;

// Expanded instruction, op in the top nibble
// Register fields carry 3-bit numbers, top bit stays zero
typedef struct packed {
        exp_op_e     op;
        logic [3:0]  rd;
        logic [3:0]  rn;
        logic [3:0]  rs;
        logic [15:0] imm;
} exp_instr_t;

// Splitter FSM
typedef enum logic [1:0] {
        SPLIT_IDLE = 2'd0,
        SPLIT_LOW  = 2'd1,
        SPLIT_HIGH = 2'd2
} split_state_e;

endpackage

//--- logic/cpu_front_top.sv
`timescale 1ns/1ns

module cpu_front_top import cpu_front_pkg::*; (
        input  logic                         i_clk,
        input  logic                         i_reset,

        // Pipeline control
        input  logic                         i_flush,
        input  logic                         i_stall,
        input  logic                         i_irq,

        // Fetch words
        input  logic                         i_fetch_valid,
        input  logic [2*HALF_W-1:0]          i_fetch_word,
        input  logic [ADDR_W-1:0]            i_fetch_pc,
        output logic                         o_fetch_hold,

        // Decoded output, flattened expanded form
        output logic                         o_valid,
        output logic [$bits(exp_instr_t)-1:0] o_instr,
        output logic [ADDR_W-1:0]            o_pc,
        output logic                         o_und,
        output logic                         o_irq
);

// --------------------------------------------------
// Internal buses
// --------------------------------------------------

half_push_if push_bus ();
half_pop_if  pop_bus ();

// --------------------------------------------------
// Splitter, queue, decode
// --------------------------------------------------

halfword_splitter u_halfword_splitter (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_flush       (i_flush),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch_word  (i_fetch_word),
        .i_fetch_pc    (i_fetch_pc),
        .o_fetch_hold  (o_fetch_hold),
        .push          (push_bus.producer)
);

instr_queue u_instr_queue (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_flush (i_flush),
        .push    (push_bus.buffer),
        .pop     (pop_bus.buffer)
);

// Packed struct output lands directly on the flat port
decode_stage u_decode_stage (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_flush (i_flush),
        .i_stall (i_stall),
        .i_irq   (i_irq),
        .src     (pop_bus.consumer),
        .o_valid (o_valid),
        .o_instr (o_instr),
        .o_pc    (o_pc),
        .o_und   (o_und),
        .o_irq   (o_irq)
);

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ns

module decode_stage import cpu_front_pkg::*; (
        input  logic              i_clk,
        input  logic              i_reset,

        // Pipeline control, flush wins over stall
        input  logic              i_flush,
        input  logic              i_stall,

        // Interrupt level
        input  logic              i_irq,

        // From the queue
        half_pop_if.consumer      src,

        // Registered expanded instruction
        output logic              o_valid,
        output exp_instr_t        o_instr,
        output logic [ADDR_W-1:0] o_pc,
        output logic              o_und,
        output logic              o_irq
);

exp_instr_t exp_instr;
logic       exp_und;
logic       exp_irq;
logic       load;

thumb_expander u_thumb_expander (
        .i_half  (src.half),
        .i_irq   (i_irq),
        .o_instr (exp_instr),
        .o_und   (exp_und),
        .o_irq   (exp_irq)
);

// Stage advances only with no flush and no stall
assign load    = !i_flush && !i_stall;
assign src.pop = load && src.valid;

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_valid <= 1'b0;
                o_instr <= '0;
                o_pc    <= '0;
                o_und   <= 1'b0;
                o_irq   <= 1'b0;
        end
        else if (i_flush)
        begin
                o_valid <= 1'b0;
                o_und   <= 1'b0;
                o_irq   <= 1'b0;
        end
        else if (i_stall)
        begin
                // Hold everything
        end
        else
        begin
                o_valid <= src.valid;
                o_und   <= src.valid && exp_und;
                o_irq   <= src.valid && exp_irq;

                // Keep the last instruction when the queue runs dry
                if (src.valid)
                begin
                        o_instr <= exp_instr;
                        o_pc    <= src.pc;
                end
        end
end

// Interrupt substitution always masks the undefined flag
a_und_irq_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_und && o_irq));

endmodule

//--- logic/halfword_if.sv
`timescale 1ns/1ns

// Splitter to queue, one halfword per accepted push
interface half_push_if import cpu_front_pkg::*; ();
        logic              push;
        logic [HALF_W-1:0] half;
        logic [ADDR_W-1:0] pc;
        logic              full;

        modport producer (output push, half, pc, input full);
        modport buffer (input push, half, pc, output full);
endinterface

// Queue to decode stage, oldest entry shown while valid
interface half_pop_if import cpu_front_pkg::*; ();
        logic              valid;
        logic [HALF_W-1:0] half;
        logic [ADDR_W-1:0] pc;
        logic              pop;

        modport buffer (output valid, half, pc, input pop);
        modport consumer (input valid, half, pc, output pop);
endinterface

//--- logic/halfword_splitter.sv
`timescale 1ns/1ns

module halfword_splitter import cpu_front_pkg::*; (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_flush,

        // Fetch side
        input  logic                  i_fetch_valid,
        input  logic [2*HALF_W-1:0]   i_fetch_word,
        input  logic [ADDR_W-1:0]     i_fetch_pc,
        output logic                  o_fetch_hold,

        // Queue side
        half_push_if.producer         push
);

split_state_e state;

// Held fetch word and its word-aligned PC
logic [2*HALF_W-1:0] word_q;
logic [ADDR_W-1:0]   pc_q;

logic accept;

// --------------------------------------------------
// Handshake with fetch
// --------------------------------------------------

// Low half still pending, or high half blocked by a full queue
assign o_fetch_hold = (state == SPLIT_LOW) || ((state == SPLIT_HIGH) && push.full);

// Flush cycle drops whatever fetch offers
assign accept = i_fetch_valid && !o_fetch_hold && !i_flush;

// --------------------------------------------------
// Handshake with the queue
// --------------------------------------------------

assign push.push = ((state == SPLIT_LOW) || (state == SPLIT_HIGH)) && !push.full;

// Low half first, then high half at PC plus 2
assign push.half = (state == SPLIT_HIGH) ? word_q[2*HALF_W-1:HALF_W] : word_q[HALF_W-1:0];
assign push.pc   = (state == SPLIT_HIGH) ? pc_q + ADDR_W'(2) : pc_q;

always_ff @(posedge i_clk)
begin
        if (i_reset)
                state <= SPLIT_IDLE;
        else if (i_flush)
                state <= SPLIT_IDLE;
        else
        begin
                case (state)
                SPLIT_IDLE:
                        if (accept)
                                state <= SPLIT_LOW;
                SPLIT_LOW:
                        if (!push.full)
                                state <= SPLIT_HIGH;
                SPLIT_HIGH:
                        // Next word may arrive in the same cycle as the last push
                        if (!push.full)
                                state <= accept ? SPLIT_LOW : SPLIT_IDLE;
                default:
                        state <= SPLIT_IDLE;
                endcase
        end
end

// Payload
always_ff @(posedge i_clk)
begin
        if (accept)
        begin
                word_q <= i_fetch_word;
                pc_q   <= i_fetch_pc;
        end
end

// Fetch delivers aligned words only
a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
        accept |-> (i_fetch_pc[1:0] == 2'b00));

// A full queue freezes the FSM so no pending half slips past it
a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset || i_flush)
        (push.full && (state != SPLIT_IDLE)) |=> $stable(state));

endmodule

//--- logic/instr_queue.sv
`timescale 1ns/1ns

module instr_queue import cpu_front_pkg::*; (
        input  logic          i_clk,
        input  logic          i_reset,
        input  logic          i_flush,

        // Writer side
        half_push_if.buffer   push,

        // Reader side, first word falls through
        half_pop_if.buffer    pop
);

// Storage, no reset on the entries themselves
logic [HALF_W-1:0] half_mem [QUEUE_DEPTH];
logic [ADDR_W-1:0] pc_mem   [QUEUE_DEPTH];

logic [PTR_W-1:0]   wr_ptr;
logic [PTR_W-1:0]   rd_ptr;
logic [COUNT_W-1:0] count;

logic do_push;
logic do_pop;

// --------------------------------------------------
// Status
// --------------------------------------------------

assign push.full = (count == COUNT_W'(QUEUE_DEPTH));
assign pop.valid = (count != '0);

// Oldest entry
assign pop.half = half_mem[rd_ptr];
assign pop.pc   = pc_mem[rd_ptr];

// A push into a full queue is not counted
assign do_push = push.push && !push.full;
assign do_pop  = pop.pop && pop.valid;

// --------------------------------------------------
// Pointers and count
// --------------------------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset || i_flush)
        begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
        end
        else
        begin
                if (do_push)
                        wr_ptr <= wr_ptr + PTR_W'(1);
                if (do_pop)
                        rd_ptr <= rd_ptr + PTR_W'(1);

                // Simultaneous push and pop leave the count alone
                case ({do_push, do_pop})
                2'b10:   count <= count + COUNT_W'(1);
                2'b01:   count <= count - COUNT_W'(1);
                default: count <= count;
                endcase
        end
end

always_ff @(posedge i_clk)
begin
        if (do_push)
        begin
                half_mem[wr_ptr] <= push.half;
                pc_mem[wr_ptr]   <= push.pc;
        end
end

// Decode stage only pops what it sees
a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset)
        pop.pop |-> pop.valid);

a_count_bound: assert property (@(posedge i_clk) disable iff (i_reset)
        count <= COUNT_W'(QUEUE_DEPTH));

endmodule

//--- logic/thumb_expander.sv
`timescale 1ns/1ns

module thumb_expander import cpu_front_pkg::*; (
        input  logic [HALF_W-1:0] i_half,
        input  logic              i_irq,
        output exp_instr_t        o_instr,
        output logic              o_und,
        output logic              o_irq
);

c_op_e op;

// Opcode lives in the top three bits
assign op = c_op_e'(i_half[15:13]);

always_comb
begin
        // Unused fields stay zero in every form
        o_instr = '0;
        o_und   = 1'b0;
        o_irq   = 1'b0;

        if (i_irq)
        begin
                // Interrupt marker replaces the instruction, PC is kept outside
                o_instr.op = E_IRQ;
                o_irq      = 1'b1;
        end
        else
        begin
                case (op)
                C_MOVI:
                begin
                        o_instr.op  = E_MOV;
                        o_instr.rd  = {1'b0, i_half[10:8]};
                        o_instr.imm = {8'd0, i_half[7:0]};
                end

                // Register forms reserve bits 1 to 0
                C_ADDR, C_SUBR:
                begin
                        if (i_half[1:0] != 2'b00)
                        begin
                                o_instr.op = E_UND;
                                o_und      = 1'b1;
                        end
                        else
                        begin
                                o_instr.op = (op == C_ADDR) ? E_ADD : E_SUB;
                                o_instr.rd = {1'b0, i_half[10:8]};
                                o_instr.rn = {1'b0, i_half[7:5]};
                                o_instr.rs = {1'b0, i_half[4:2]};
                        end
                end

                // Same register as source and destination
                C_ADDI:
                begin
                        o_instr.op  = E_ADD;
                        o_instr.rd  = {1'b0, i_half[10:8]};
                        o_instr.rn  = {1'b0, i_half[10:8]};
                        o_instr.imm = {8'd0, i_half[7:0]};
                end

                // Word offset, scaled by four
                C_LDR, C_STR:
                begin
                        o_instr.op  = (op == C_LDR) ? E_LDR : E_STR;
                        o_instr.rd  = {1'b0, i_half[10:8]};
                        o_instr.rn  = {1'b0, i_half[7:5]};
                        o_instr.imm = {9'd0, i_half[4:0], 2'b00};
                end

                // Halfword offset from own PC, sign-extended then doubled
                C_B:
                begin
                        o_instr.op  = E_B;
                        o_instr.imm = {{4{i_half[10]}}, i_half[10:0], 1'b0};
                end

                default:
                begin
                        o_instr.op = E_UND;
                        o_und      = 1'b1;
                end
                endcase
        end
end

endmodule

//--- sim/cpu_front_tb.sv
`timescale 1ns/1ns

module cpu_front_tb import cpu_front_pkg::*; ();

// Words fetched over all tests, sizes the watchdog
localparam int TOTAL_WORDS     = 80;
localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 200;

logic                         i_clk;
logic                         i_reset;
logic                         i_flush;
logic                         i_stall;
logic                         i_irq;
logic                         i_fetch_valid;
logic [2*HALF_W-1:0]          i_fetch_word;
logic [ADDR_W-1:0]            i_fetch_pc;
logic                         o_fetch_hold;
logic                         o_valid;
logic [$bits(exp_instr_t)-1:0] o_instr;
logic [ADDR_W-1:0]            o_pc;
logic                         o_und;
logic                         o_irq;

// Expected halfwords and PCs, oldest first
logic [HALF_W-1:0] exp_half [$];
logic [ADDR_W-1:0] exp_pc [$];

logic [31:0]       lcg_state;
logic [ADDR_W-1:0] next_pc;

// Stage control seen at the last rising edge
logic load_seen;
logic irq_seen;

int accept_count;
int und_count;
int irq_count;

cpu_front_top dut0 (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_flush       (i_flush),
        .i_stall       (i_stall),
        .i_irq         (i_irq),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch_word  (i_fetch_word),
        .i_fetch_pc    (i_fetch_pc),
        .o_fetch_hold  (o_fetch_hold),
        .o_valid       (o_valid),
        .o_instr       (o_instr),
        .o_pc          (o_pc),
        .o_und         (o_und),
        .o_irq         (o_irq)
);

initial
begin
        i_clk = 1'b0;
        forever
                #50 i_clk = ~i_clk;
end

// --------------------------------------------------
// Reporting and compares
// --------------------------------------------------

task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
endtask

task automatic compare_instr(input exp_instr_t got, input exp_instr_t exp, input string name);
        if (got !== exp)
                report_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
endtask

task automatic compare_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
                input string name);
        if (got !== exp)
                report_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
endtask

task automatic compare_flag(input logic got, input logic exp, input string name);
        if (got !== exp)
                report_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
endtask

// --------------------------------------------------
// Reference model and random data
// --------------------------------------------------

// Expansion rules of the compressed set, PC passes through
function automatic void expand_model(
        input  logic [HALF_W-1:0] half,
        input  logic              irq,
        input  logic [ADDR_W-1:0] pc,
        output exp_instr_t        instr,
        output logic              und,
        output logic              irq_out,
        output logic [ADDR_W-1:0] pc_out);
        logic [2:0]         opc;
        logic [3:0]         rd;
        logic [3:0]         rn;
        logic [3:0]         rs;
        logic signed [15:0] boff;
        opc     = half[15:13];
        rd      = {1'b0, half[10:8]};
        rn      = {1'b0, half[7:5]};
        rs      = {1'b0, half[4:2]};
        // Branch offset in halfwords, sign-extended
        boff    = {{5{half[10]}}, half[10:0]};
        instr   = '0;
        und     = 1'b0;
        irq_out = 1'b0;
        pc_out  = pc;
        if (irq)
        begin
                instr.op = E_IRQ;
                irq_out  = 1'b1;
        end
        else if (opc == 3'd7 || ((opc == 3'd1 || opc == 3'd2) && half[1:0] != 2'b00))
        begin
                instr.op = E_UND;
                und      = 1'b1;
        end
        else
        begin
                case (opc)
                3'd0:
                begin
                        instr.op  = E_MOV;
                        instr.rd  = rd;
                        instr.imm = 16'(half[7:0]);
                end
                3'd1, 3'd2:
                begin
                        instr.op = (opc == 3'd1) ? E_ADD : E_SUB;
                        instr.rd = rd;
                        instr.rn = rn;
                        instr.rs = rs;
                end
                3'd3:
                begin
                        instr.op  = E_ADD;
                        instr.rd  = rd;
                        instr.rn  = rd;
                        instr.imm = 16'(half[7:0]);
                end
                3'd4, 3'd5:
                begin
                        instr.op  = (opc == 3'd4) ? E_LDR : E_STR;
                        instr.rd  = rd;
                        instr.rn  = rn;
                        instr.imm = 16'(half[4:0]) * 16'd4;
                end
                default:
                begin
                        // Byte offset is twice the halfword count
                        instr.op  = E_B;
                        instr.imm = boff + boff;
                end
                endcase
        end
endfunction

function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
endfunction

// --------------------------------------------------
// Scoreboard monitor
// --------------------------------------------------

always @(posedge i_clk)
begin
        load_seen = !i_reset && !i_stall && !i_flush;
        irq_seen  = i_irq;
end

task automatic check_output();
        logic [HALF_W-1:0] half;
        logic [ADDR_W-1:0] pc;
        exp_instr_t        e_instr;
        logic              e_und;
        logic              e_irq;
        logic [ADDR_W-1:0] e_pc;
        if (exp_half.size() == 0)
                report_error("an instruction came out with none outstanding");
        else
        begin
                half = exp_half.pop_front();
                pc   = exp_pc.pop_front();
                expand_model(half, irq_seen, pc, e_instr, e_und, e_irq, e_pc);
                compare_instr(exp_instr_t'(o_instr), e_instr, "o_instr");
                compare_addr(o_pc, e_pc, "o_pc");
                compare_flag(o_und, e_und, "o_und");
                compare_flag(o_irq, e_irq, "o_irq");
                if (o_und)
                        und_count++;
                if (o_irq)
                        irq_count++;
        end
endtask

// Outputs are new only after an edge where the stage loaded
always @(negedge i_clk)
begin
        if (load_seen && o_valid)
                check_output();
end

initial
begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        report_error("watchdog expired before the tests completed");
end

// --------------------------------------------------
// Fetch driver
// --------------------------------------------------

task automatic drive_slot();
        @(posedge i_clk);
        #10;
endtask

// Offer one word until it is accepted, then expect both halves
task automatic send_word(input logic [2*HALF_W-1:0] word);
        logic taken;
        taken         = 1'b0;
        i_fetch_valid = 1'b1;
        i_fetch_word  = word;
        i_fetch_pc    = next_pc;
        while (!taken)
        begin
                @(negedge i_clk);
                taken = !o_fetch_hold && !i_flush;
                drive_slot();
        end
        exp_half.push_back(word[HALF_W-1:0]);
        exp_pc.push_back(next_pc);
        exp_half.push_back(word[2*HALF_W-1:HALF_W]);
        exp_pc.push_back(next_pc + 32'd2);
        next_pc       = next_pc + 32'd4;
        accept_count++;
        i_fetch_valid = 1'b0;
endtask

task automatic send_random_words(input int n);
        repeat (n)
                send_word(lcg_next());
endtask

task automatic wait_drain();
        while (exp_half.size() != 0)
                @(posedge i_clk);
        repeat (2) @(posedge i_clk);
        #10;
endtask

// --------------------------------------------------
// Tests
// --------------------------------------------------

task automatic test_reset();
        @(negedge i_clk);
        compare_flag(o_valid, 1'b0, "o_valid");
        compare_flag(o_und, 1'b0, "o_und");
        compare_flag(o_irq, 1'b0, "o_irq");
        compare_flag(o_fetch_hold, 1'b0, "o_fetch_hold");
        compare_instr(exp_instr_t'(o_instr), '0, "o_instr");
        compare_addr(o_pc, '0, "o_pc");
        drive_slot();
endtask

task automatic test_expand_all();
        int n;
        // MOVI and ADD register first, alone for the latency check
        send_word(32'h2354_05a5);
        n = 0;
        do
        begin
                @(negedge i_clk);
                n++;
        end
        while (!o_valid && n < 10);
        if (n != 3)
                report_error($sformatf("first output came %0d cycles after fetch, not 3", n));
        drive_slot();
        // ADD immediate, SUB register, largest LDR offset, STR, both branch signs
        send_word(32'h61ff_47fc);
        send_word(32'ha425_827f);
        send_word(32'hc123_c7f0);
        send_word(32'hffff_0000);
        send_random_words(40);
        wait_drain();
endtask

task automatic test_undefined();
        int und_before;
        und_before = und_count;
        // High half of each word is the low half's legal neighbor where one exists
        send_word(32'hffff_e000);
        send_word(32'h2000_2001);
        send_word(32'h47fc_4002);
        send_word(32'h5ffc_2003);
        send_word(32'h6003_dfff);
        wait_drain();
        if (und_count - und_before != 5)
                report_error("wrong number of undefined instructions flagged");
endtask

task automatic test_stall();
        exp_instr_t        ref_instr;
        logic [ADDR_W-1:0] ref_pc;
        logic              ref_valid;
        int                acc_before;
        fork
                send_random_words(12);
                begin
                        repeat (6) drive_slot();
                        i_stall    = 1'b1;
                        acc_before = accept_count;
                        @(negedge i_clk);
                        ref_instr  = exp_instr_t'(o_instr);
                        ref_pc     = o_pc;
                        ref_valid  = o_valid;
                        repeat (9)
                        begin
                                @(negedge i_clk);
                                compare_instr(exp_instr_t'(o_instr), ref_instr, "o_instr");
                                compare_addr(o_pc, ref_pc, "o_pc");
                                compare_flag(o_valid, ref_valid, "o_valid");
                        end
                        // Queue is full by now and fetch is held off
                        compare_flag(o_fetch_hold, 1'b1, "o_fetch_hold");
                        if (accept_count - acc_before > QUEUE_DEPTH / 2 + 1)
                                report_error("more words accepted during stall than fit");
                        drive_slot();
                        i_stall = 1'b0;
                end
        join
        wait_drain();
endtask

task automatic test_flush();
        fork
                send_random_words(8);
                begin
                        repeat (7) drive_slot();
                        i_flush = 1'b1;
                        @(posedge i_clk);
                        // Everything in flight is gone at this edge
                        exp_half.delete();
                        exp_pc.delete();
                        #10;
                        i_flush = 1'b0;
                        @(negedge i_clk);
                        compare_flag(o_valid, 1'b0, "o_valid");
                        drive_slot();
                end
        join
        wait_drain();
endtask

task automatic test_irq();
        int irq_before;
        irq_before = irq_count;
        fork
                send_random_words(10);
                begin
                        repeat (5) drive_slot();
                        i_irq = 1'b1;
                        repeat (4) drive_slot();
                        i_irq = 1'b0;
                end
        join
        wait_drain();
        // Window covers some but not all of the 20 halfwords
        if (irq_count == irq_before)
                report_error("no interrupt marker came out during the interrupt window");
        if (irq_count - irq_before >= 20)
                report_error("instructions outside the interrupt window were replaced");
endtask

// --------------------------------------------------
// Main sequence
// --------------------------------------------------

initial
begin
        i_reset       = 1'b1;
        i_flush       = 1'b0;
        i_stall       = 1'b0;
        i_irq         = 1'b0;
        i_fetch_valid = 1'b0;
        i_fetch_word  = '0;
        i_fetch_pc    = '0;
        lcg_state     = 32'hc38729ed;
        next_pc       = 32'h0000_1000;
        load_seen     = 1'b0;
        irq_seen      = 1'b0;
        accept_count  = 0;
        und_count     = 0;
        irq_count     = 0;
        repeat (4) @(posedge i_clk);
        #10;
        i_reset = 1'b0;

        test_reset();
        test_expand_all();
        test_undefined();
        test_stall();
        test_flush();
        test_irq();

        if (exp_half.size() == 0)
        begin
                $display("Test passed");
                $finish;
        end
        else
                report_error("scoreboard still holds instructions at the end");
end

endmodule

//--- src.f
logic/cpu_front_pkg.sv
logic/halfword_if.sv
logic/halfword_splitter.sv
logic/instr_queue.sv
logic/thumb_expander.sv
logic/decode_stage.sv
logic/cpu_front_top.sv
sim/cpu_front_tb.sv
